//--- build.f
+incdir+.
ex_pkg.sv
fu_result_if.sv
ex_operand_select.sv
ex_alu.sv
ex_mult.sv
ex_branch.sv
ex_control.sv
ex_stage.sv
ex_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the execute stage testbench with Verilator, then run it
cd "$(dirname "$0")" &&
verilator --binary --timing -f build.f --top-module ex_stage_tb &&
./obj_dir/Vex_stage_tb || exit 1

//--- ex_stage_tb.sv
// Self-checking testbench for the execute stage
// LFSR stimulus on the issue port, expected results kept per tag and
// checked at every completion, including the latency of each unit
`include "ex_settings.svh"

module ex_stage_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int S       = `EX_MULT_STAGES;
    localparam int NTAGS   = 1 << `EX_TAG_W;
    localparam int N_ALU   = 42;              // Two sweeps of all operand mux pairs
    localparam int N_MULT  = 16;
    localparam int N_BR    = 28;
    localparam int N_MIX   = 60;
    localparam int N_OPS   = N_ALU + N_MULT + N_BR + S + N_MIX;
    localparam int TIMEOUT = N_OPS * (S + 2) + 100;

    // One issue as the core would present it
    typedef struct packed {
        ex_pkg::fu_type_e  fu;
        ex_pkg::alu_func_e func;
        ex_pkg::opa_sel_e  asel;
        ex_pkg::opb_sel_e  bsel;
        logic [31:0]       inst;
        logic [31:0]       pc;
        logic [31:0]       rs1;
        logic [31:0]       rs2;
        logic              uncond;
    } stim_t;

    typedef struct packed {
        logic [31:0] value;
        logic        take;
        logic [31:0] target;
    } result_t;

    logic                 clock = 1'b0;
    logic                 reset;
    logic                 issue_valid, issue_ready, issue_uncond;
    logic [`EX_TAG_W-1:0] issue_tag;
    ex_pkg::fu_type_e     issue_fu;
    ex_pkg::alu_func_e    issue_func;
    ex_pkg::opa_sel_e     issue_opa_sel;
    ex_pkg::opb_sel_e     issue_opb_sel;
    logic [`EX_XLEN-1:0]  issue_inst, issue_pc, issue_rs1, issue_rs2;
    logic                 done_valid, done_take_branch;
    logic [`EX_TAG_W-1:0] done_tag;
    logic [`EX_XLEN-1:0]  done_value, done_target;

    // Scoreboard, one entry per tag
    result_t     expected  [NTAGS];
    int          latency   [NTAGS];
    int          issued_at [NTAGS];
    int          issued    [NTAGS];   // Tag busy while issued differs from retired
    int          retired   [NTAGS];
    int          n_issued  = 0;
    int          n_retired = 0;
    int          next_tag  = 0;
    int          cycle     = 0;
    logic [31:0] lfsr      = 32'h95f6;

    ex_stage dut0 (.*);

    always #10 clock = ~clock;

    task automatic abort_run(input string why);
        $display("Test failed");
        $fatal(1, "%s", why);
    endtask

    // Watchdog
    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) abort_run("Timeout: not every operation completed in time");
    end

    //////////////////////////////
    // Stimulus and reference
    //////////////////////////////

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        end
        return r;
    endfunction

    function automatic stim_t random_stim(input ex_pkg::fu_type_e fu);
        stim_t s;
        s.fu     = fu;
        s.inst   = rand_bits(32);
        s.pc     = rand_bits(32) & 32'hffff_fffc;  // Word aligned
        s.rs1    = rand_bits(32);
        s.rs2    = rand_bits(32);
        s.uncond = 1'b0;
        s.func   = ex_pkg::ADD;
        s.asel   = ex_pkg::opa_sel_e'(2'(rand_bits(2) % 3));
        s.bsel   = ex_pkg::opb_sel_e'(3'(rand_bits(3) % 7));
        if (fu == ex_pkg::FU_ALU) begin
            s.func = ex_pkg::alu_func_e'(4'(rand_bits(4) % 10));
        end else if (fu == ex_pkg::FU_MULT) begin
            s.func = ex_pkg::alu_func_e'(ex_pkg::MUL + 4'(rand_bits(2)));
            s.asel = ex_pkg::RS1;
            s.bsel = ex_pkg::RS2;
        end else begin
            s.uncond = rand_bits(1) != 0;                 // Jump
            s.asel   = (s.uncond && rand_bits(1) != 0) ? ex_pkg::RS1 : ex_pkg::PC;
            s.bsel   = !s.uncond ? ex_pkg::B_IMM :
                       (s.asel == ex_pkg::RS1) ? ex_pkg::I_IMM : ex_pkg::J_IMM;
        end
        return s;
    endfunction

    // Expected completion from the RV32IM rules
    function automatic result_t reference(input stim_t s);
        logic [31:0] a, b;
        logic [63:0] prod;
        logic        cond;
        result_t     r;
        r    = '0;
        prod = '0;
        case (s.asel)
            ex_pkg::RS1: a = s.rs1;
            ex_pkg::PC:  a = s.pc;
            default:     a = '0;
        endcase
        // Sign extension by arithmetic right shift of the left-packed field
        case (s.bsel)
            ex_pkg::RS2:   b = s.rs2;
            ex_pkg::I_IMM: b = $signed({s.inst[31:20], 20'b0}) >>> 20;
            ex_pkg::S_IMM: b = $signed({s.inst[31:25], s.inst[11:7], 20'b0}) >>> 20;
            ex_pkg::B_IMM: b = $signed({s.inst[31], s.inst[7], s.inst[30:25],
                                        s.inst[11:8], 1'b0, 19'b0}) >>> 19;
            ex_pkg::U_IMM: b = {s.inst[31:12], 12'b0};
            ex_pkg::J_IMM: b = $signed({s.inst[31], s.inst[19:12], s.inst[20],
                                        s.inst[30:21], 1'b0, 11'b0}) >>> 11;
            default:       b = 32'd4;
        endcase
        case (s.inst[14:12])
            3'b000:  cond = s.rs1 == s.rs2;
            3'b001:  cond = s.rs1 != s.rs2;
            3'b100:  cond = $signed(s.rs1) < $signed(s.rs2);
            3'b101:  cond = $signed(s.rs1) >= $signed(s.rs2);
            3'b110:  cond = s.rs1 < s.rs2;
            3'b111:  cond = s.rs1 >= s.rs2;
            default: cond = 1'b0;                        // Not a branch encoding
        endcase
        if (s.fu == ex_pkg::FU_BRANCH) begin
            r.value  = s.pc + 32'd4;                     // Link
            r.take   = s.uncond | cond;
            r.target = (a + b) & ~32'd1;
        end else begin
            case (s.func)
                ex_pkg::ADD:    r.value = a + b;
                ex_pkg::SUB:    r.value = a - b;
                ex_pkg::AND:    r.value = a & b;
                ex_pkg::OR:     r.value = a | b;
                ex_pkg::XOR:    r.value = a ^ b;
                ex_pkg::SLT:    r.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                ex_pkg::SLTU:   r.value = (a < b) ? 32'd1 : 32'd0;
                ex_pkg::SLL:    r.value = a << b[4:0];
                ex_pkg::SRL:    r.value = a >> b[4:0];
                ex_pkg::SRA:    r.value = $signed(a) >>> b[4:0];
                ex_pkg::MUL:    r.value = a * b;         // Low word, same for any sign
                ex_pkg::MULH:   prod = longint'($signed(a)) * longint'($signed(b));
                ex_pkg::MULHSU: prod = longint'($signed(a)) * longint'({32'b0, b});
                default:        prod = {32'b0, a} * {32'b0, b};
            endcase
            if (s.func inside {ex_pkg::MULH, ex_pkg::MULHSU, ex_pkg::MULHU}) begin
                r.value = prod[63:32];
            end
        end
        return r;
    endfunction

    task automatic drive_inputs(input logic valid, input logic [`EX_TAG_W-1:0] tag,
                                input stim_t s);
        issue_valid   <= valid;
        issue_tag     <= tag;
        issue_fu      <= s.fu;
        issue_func    <= s.func;
        issue_opa_sel <= s.asel;
        issue_opb_sel <= s.bsel;
        issue_inst    <= s.inst;
        issue_pc      <= s.pc;
        issue_rs1     <= s.rs1;
        issue_rs2     <= s.rs2;
        issue_uncond  <= s.uncond;
    endtask

    // One issue attempt, accepted reports the edge that follows
    task automatic offer(input stim_t s, output logic accepted);
        logic [`EX_TAG_W-1:0] t;
        logic                 found;
        @(posedge clock);
        found = 1'b0;
        for (int i = 0; i < NTAGS && !found; i++) begin
            t     = `EX_TAG_W'(next_tag + i);
            found = (issued[t] == retired[t]);           // Free tag
        end
        drive_inputs(found, t, s);
        @(negedge clock);
        accepted = found && issue_ready;
        if (accepted) begin
            expected[t]  = reference(s);
            latency[t]   = (s.fu == ex_pkg::FU_MULT) ? S : 1;
            issued_at[t] = cycle;
            issued[t]++;
            n_issued++;
            next_tag++;
        end
    endtask

    task automatic issue_op(input stim_t s);
        logic acc;
        acc = 1'b0;
        while (!acc) begin
            offer(s, acc);                               // Retry on a booked slot
        end
    endtask

    task automatic idle();
        @(posedge clock);
        issue_valid <= 1'b0;
    endtask

    task automatic drain();
        idle();
        while (n_retired != n_issued) @(posedge clock);
    endtask

    //////////////////////////////
    // Completion checks
    //////////////////////////////

    always @(negedge clock) begin : compare
        logic [`EX_TAG_W-1:0] t;
        if (!reset && done_valid) begin
            t = done_tag;
            assert (issued[t] != retired[t]) else begin
                $display("ERR %0t: completion for tag %0d, not outstanding", $time, t);
                abort_run("Completion without a matching issue");
            end
            assert (done_value == expected[t].value && done_take_branch == expected[t].take
                    && done_target == expected[t].target) else begin
                $display("ERR %0t: tag %0d got %h/%b/%h, expected %h/%b/%h", $time, t,
                         done_value, done_take_branch, done_target, expected[t].value,
                         expected[t].take, expected[t].target);
                abort_run("Completion fields differ from the reference");
            end
            assert (cycle - issued_at[t] == latency[t]) else begin
                $display("ERR %0t: tag %0d latency %0d, expected %0d", $time, t,
                         cycle - issued_at[t], latency[t]);
                abort_run("Completion latency is wrong");
            end
            retired[t]++;
            n_retired++;
        end
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        stim_t       s;
        logic        acc;
        logic [31:0] corner [6];
        logic [31:0] bra    [4];
        logic [31:0] brb    [4];
        logic [2:0]  conds  [6];
        corner = '{32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff, 32'h0, 32'h1, 32'h1234_5678};
        bra    = '{32'd7, 32'd3, 32'hffff_fff0, 32'd5};  // Equal, less, neg/pos, pos/neg
        brb    = '{32'd7, 32'd9, 32'd5, 32'hffff_fff0};
        conds  = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        reset <= 1'b1;
        drive_inputs(1'b0, '0, random_stim(ex_pkg::FU_ALU));
        repeat (4) @(posedge clock);
        reset <= 1'b0;

        // Idle state after reset, every unit type ready
        for (int f = 0; f < 3; f++) begin
            @(posedge clock);
            issue_fu <= ex_pkg::fu_type_e'(2'(f));
            @(negedge clock);
            assert (issue_ready && !done_valid) else begin
                $display("ERR %0t: unit %0d after reset, ready %b done_valid %b", $time, f,
                         issue_ready, done_valid);
                abort_run("Wrong idle state after reset");
            end
        end

        for (int i = 0; i < N_ALU; i++) begin
            s      = random_stim(ex_pkg::FU_ALU);
            s.asel = ex_pkg::opa_sel_e'(2'(i % 3));
            s.bsel = ex_pkg::opb_sel_e'(3'(i % 7));
            issue_op(s);
        end
        drain();

        // Back-to-back multiplies, never refused
        for (int i = 0; i < N_MULT; i++) begin
            s      = random_stim(ex_pkg::FU_MULT);
            s.func = ex_pkg::alu_func_e'(ex_pkg::MUL + 4'(i % 4));
            s.rs1  = corner[i % 6];
            s.rs2  = corner[(i + i / 6 + 1) % 6];
            offer(s, acc);
            assert (acc) else abort_run("A multiply was refused with the multiplier idle");
        end
        drain();

        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 4; p++) begin
                s             = random_stim(ex_pkg::FU_BRANCH);
                s.uncond      = 1'b0;
                s.asel        = ex_pkg::PC;
                s.bsel        = ex_pkg::B_IMM;
                s.inst[14:12] = conds[c];
                s.rs1         = bra[p];
                s.rs2         = brb[p];
                issue_op(s);
            end
        end
        for (int j = 0; j < 4; j++) begin
            s        = random_stim(ex_pkg::FU_BRANCH);
            s.uncond = 1'b1;                              // JAL, then JALR
            s.asel   = j[0] ? ex_pkg::RS1 : ex_pkg::PC;
            s.bsel   = j[0] ? ex_pkg::I_IMM : ex_pkg::J_IMM;
            issue_op(s);
        end
        drain();

        // Slot collision, single-cycle op lands on the multiply's slot
        offer(random_stim(ex_pkg::FU_MULT), acc);
        assert (acc) else abort_run("A multiply was refused with the multiplier idle");
        for (int k = 1; k <= S - 2; k++) begin
            offer(random_stim(ex_pkg::FU_ALU), acc);
            assert (acc) else abort_run("An ALU op was refused on a free slot");
        end
        s = random_stim(ex_pkg::FU_ALU);
        offer(s, acc);
        assert (!acc) else begin
            $display("ERR %0t: issue_ready high on the slot booked by a multiply", $time);
            abort_run("Completion slot collision was not refused");
        end
        offer(s, acc);
        assert (acc) else abort_run("An ALU op was refused one cycle after the collision");

        for (int i = 0; i < N_MIX; i++) begin
            if (rand_bits(2) == 0) begin
                idle();                                   // Random gap
            end else begin
                issue_op(random_stim(ex_pkg::fu_type_e'(2'(rand_bits(2) % 3))));
            end
        end
        drain();
        repeat (S + 2) @(posedge clock);                  // No stray completions

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- ex_stage.sv
// Execute stage top level for the RV32IM core
// One tagged issue per cycle in, one tagged completion per cycle out
`include "ex_settings.svh"

module ex_stage (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 issue_valid,
    output logic                 issue_ready,
    input  logic [`EX_TAG_W-1:0] issue_tag,
    input  ex_pkg::fu_type_e     issue_fu,
    input  ex_pkg::alu_func_e    issue_func,
    input  ex_pkg::opa_sel_e     issue_opa_sel,
    input  ex_pkg::opb_sel_e     issue_opb_sel,
    input  logic [`EX_XLEN-1:0]  issue_inst,
    input  logic [`EX_XLEN-1:0]  issue_pc,
    input  logic [`EX_XLEN-1:0]  issue_rs1,
    input  logic [`EX_XLEN-1:0]  issue_rs2,
    input  logic                 issue_uncond,
    output logic                 done_valid,
    output logic [`EX_TAG_W-1:0] done_tag,
    output logic [`EX_XLEN-1:0]  done_value,
    output logic                 done_take_branch,
    output logic [`EX_XLEN-1:0]  done_target
);

    ex_pkg::fu_op_t op;            // Shared by all units
    logic           alu_start, mult_start, branch_start;

    fu_result_if alu_res ();
    fu_result_if mult_res ();
    fu_result_if branch_res ();

    ex_operand_select opsel0 (
        .inst(issue_inst), .pc(issue_pc), .rs1(issue_rs1), .rs2(issue_rs2),
        .opa_sel(issue_opa_sel), .opb_sel(issue_opb_sel), .tag(issue_tag),
        .func(issue_func), .uncond(issue_uncond), .op(op)
    );

    ex_alu alu0 (.clock(clock), .reset(reset), .start(alu_start), .op(op), .result(alu_res));
    ex_mult mult0 (.clock(clock), .reset(reset), .start(mult_start), .op(op),
                   .result(mult_res));
    ex_branch branch0 (.clock(clock), .reset(reset), .start(branch_start), .op(op),
                       .result(branch_res));

    ex_control ctrl0 (
        .clock(clock), .reset(reset),
        .issue_valid(issue_valid), .issue_fu(issue_fu), .issue_ready(issue_ready),
        .alu_start(alu_start), .mult_start(mult_start), .branch_start(branch_start),
        .alu_res(alu_res), .mult_res(mult_res), .branch_res(branch_res),
        .done_valid(done_valid), .done_tag(done_tag), .done_value(done_value),
        .done_take_branch(done_take_branch), .done_target(done_target)
    );

endmodule

//--- ex_control.sv
// Issue steering and completion slot booking for the execute stage
// Refuses issues whose completion cycle is already taken, then muxes
// the single valid unit result onto the shared completion port
`include "ex_settings.svh"

module ex_control (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 issue_valid,
    input  ex_pkg::fu_type_e     issue_fu,
    output logic                 issue_ready,
    output logic                 alu_start,
    output logic                 mult_start,
    output logic                 branch_start,
    fu_result_if.sink            alu_res,
    fu_result_if.sink            mult_res,
    fu_result_if.sink            branch_res,
    output logic                 done_valid,
    output logic [`EX_TAG_W-1:0] done_tag,
    output logic [`EX_XLEN-1:0]  done_value,
    output logic                 done_take_branch,
    output logic [`EX_XLEN-1:0]  done_target
);

    localparam int S = `EX_MULT_STAGES;

    // Bit i set: completion port busy i+1 cycles from now
    logic [S-1:0] book_q;
    logic [S-1:0] book_set;
    logic         accept;

    //////////////////////////////
    // Issue side
    //////////////////////////////

    // Multiply looks S cycles ahead, the rest one cycle ahead
    assign issue_ready = (issue_fu == ex_pkg::FU_MULT) ? ~book_q[S-1] : ~book_q[0];
    assign accept      = issue_valid & issue_ready;

    assign alu_start    = accept & (issue_fu == ex_pkg::FU_ALU);
    assign mult_start   = accept & (issue_fu == ex_pkg::FU_MULT);
    assign branch_start = accept & (issue_fu == ex_pkg::FU_BRANCH);

    always_comb begin
        book_set        = '0;
        book_set[0]     = alu_start | branch_start;
        book_set[S-1]   = book_set[S-1] | mult_start;
    end

    // Advance one slot per cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            book_q <= '0;
        end else begin
            book_q <= (book_q | book_set) >> 1;
        end
    end

    //////////////////////////////
    // Completion mux
    //////////////////////////////

    always_comb begin
        done_valid = alu_res.valid | mult_res.valid | branch_res.valid;
        if (mult_res.valid) begin
            done_tag         = mult_res.tag;
            done_value       = mult_res.value;
            done_take_branch = mult_res.take_branch;
            done_target      = mult_res.target;
        end else if (branch_res.valid) begin
            done_tag         = branch_res.tag;
            done_value       = branch_res.value;
            done_take_branch = branch_res.take_branch;
            done_target      = branch_res.target;
        end else begin     // ALU, or idle
            done_tag         = alu_res.tag;
            done_value       = alu_res.value;
            done_take_branch = alu_res.take_branch;
            done_target      = alu_res.target;
        end
    end

endmodule

//--- ex_branch.sv
// Branch unit: condition, target and link value
// One-cycle latency, same timing as the ALU
`include "ex_settings.svh"

module ex_branch (
    input  logic           clock,
    input  logic           reset,
    input  ex_pkg::fu_op_t op,
    input  logic           start,
    fu_result_if.source    result
);

    logic                 cond;
    logic                 valid_q;
    logic [`EX_TAG_W-1:0] tag_q;
    logic                 take_q;
    logic [`EX_XLEN-1:0]  target_q;
    logic [`EX_XLEN-1:0]  link_q;

    // Condition from funct3, compares raw rs1/rs2
    always_comb begin
        case (op.funct3)
            3'b000:  cond = (op.rs1 == op.rs2);                    // BEQ
            3'b001:  cond = (op.rs1 != op.rs2);                    // BNE
            3'b100:  cond = ($signed(op.rs1) <  $signed(op.rs2));  // BLT
            3'b101:  cond = ($signed(op.rs1) >= $signed(op.rs2));  // BGE
            3'b110:  cond = (op.rs1 <  op.rs2);                    // BLTU
            3'b111:  cond = (op.rs1 >= op.rs2);                    // BGEU
            default: cond = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= start;
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            tag_q    <= op.tag;
            take_q   <= op.uncond | cond;                          // Jumps always taken
            target_q <= (op.opa + op.opb) & ~`EX_XLEN'd1;          // JALR clears bit 0
            link_q   <= op.pc + `EX_XLEN'd4;
        end
    end

    assign result.valid       = valid_q;
    assign result.tag         = tag_q;
    assign result.value       = link_q;
    assign result.take_branch = take_q;
    assign result.target      = target_q;

endmodule

//--- ex_mult.sv
// Pipelined multiplier for MUL, MULH, MULHSU and MULHU
// Fixed latency of EX_MULT_STAGES, accepts a new op every cycle
`include "ex_settings.svh"

module ex_mult (
    input  logic           clock,
    input  logic           reset,
    input  logic           start,
    input  ex_pkg::fu_op_t op,
    fu_result_if.source    result
);

    localparam int S = `EX_MULT_STAGES;
    localparam int W = `EX_XLEN;

    logic             a_signed, b_signed;
    logic [2*W-1:0]   a_ext, b_ext;
    logic [2*W-1:0]   product;
    logic [S-1:0]     valid_q;
    logic [S-1:0]     hi_q;                  // Return upper word
    logic [`EX_TAG_W-1:0] tag_q  [S];
    logic [2*W-1:0]   prod_q [S];

    // Signedness per function, MULHU is fully unsigned
    assign a_signed = (op.func == ex_pkg::MUL) || (op.func == ex_pkg::MULH) ||
                      (op.func == ex_pkg::MULHSU);
    assign b_signed = (op.func == ex_pkg::MUL) || (op.func == ex_pkg::MULH);

    assign a_ext = {{W{a_signed & op.opa[W-1]}}, op.opa};
    assign b_ext = {{W{b_signed & op.opb[W-1]}}, op.opb};

    assign product = a_ext * b_ext;  // Low 2W bits are exact for both signednesses

    //////////////////////////////
    // Register chain
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[S-2:0], start};
        end
    end

    always_ff @(posedge clock) begin
        tag_q[0]  <= op.tag;
        hi_q[0]   <= (op.func != ex_pkg::MUL);
        prod_q[0] <= product;
        for (int i = 1; i < S; i++) begin
            tag_q[i]  <= tag_q[i-1];
            hi_q[i]   <= hi_q[i-1];
            prod_q[i] <= prod_q[i-1];
        end
    end

    // Last stage drives the completion bundle
    assign result.valid       = valid_q[S-1];
    assign result.tag         = tag_q[S-1];
    assign result.value       = hi_q[S-1] ? prod_q[S-1][2*W-1:W] : prod_q[S-1][W-1:0];
    assign result.take_branch = 1'b0;
    assign result.target      = '0;

endmodule

//--- ex_alu.sv
// Single-cycle integer ALU
// Result appears on the completion bundle one cycle after start
`include "ex_settings.svh"

module ex_alu (
    input  logic           clock,
    input  logic           reset,
    input  logic           start,
    input  ex_pkg::fu_op_t op,
    fu_result_if.source    result
);

    logic [`EX_XLEN-1:0]  alu_out;
    logic [4:0]           shamt;
    logic                 valid_q;
    logic [`EX_TAG_W-1:0] tag_q;
    logic [`EX_XLEN-1:0]  value_q;

    assign shamt = op.opb[4:0];  // RV32 shift amount

    always_comb begin
        case (op.func)
            ex_pkg::ADD:  alu_out = op.opa + op.opb;
            ex_pkg::SUB:  alu_out = op.opa - op.opb;
            ex_pkg::AND:  alu_out = op.opa & op.opb;
            ex_pkg::OR:   alu_out = op.opa | op.opb;
            ex_pkg::XOR:  alu_out = op.opa ^ op.opb;
            ex_pkg::SLT:  alu_out = {{(`EX_XLEN-1){1'b0}}, $signed(op.opa) < $signed(op.opb)};
            ex_pkg::SLTU: alu_out = {{(`EX_XLEN-1){1'b0}}, op.opa < op.opb};
            ex_pkg::SLL:  alu_out = op.opa << shamt;
            ex_pkg::SRL:  alu_out = op.opa >> shamt;
            ex_pkg::SRA:  alu_out = $signed(op.opa) >>> shamt;  // Sign fill
            default:      alu_out = '0;        // Multiply codes never steered here
        endcase
    end

    // Valid pulse
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= start;
        end
    end

    // Payload only loads on start
    always_ff @(posedge clock) begin
        if (start) begin
            tag_q   <= op.tag;
            value_q <= alu_out;
        end
    end

    assign result.valid       = valid_q;
    assign result.tag         = tag_q;
    assign result.value       = value_q;
    assign result.take_branch = 1'b0;
    assign result.target      = '0;

endmodule

//--- ex_operand_select.sv
// Immediate decode and operand muxing for the execute stage
// Purely combinational, feeds the same op to all three units
`include "ex_settings.svh"

module ex_operand_select (
    input  logic [`EX_XLEN-1:0]  inst,
    input  logic [`EX_XLEN-1:0]  pc,
    input  logic [`EX_XLEN-1:0]  rs1,
    input  logic [`EX_XLEN-1:0]  rs2,
    input  ex_pkg::opa_sel_e     opa_sel,
    input  ex_pkg::opb_sel_e     opb_sel,
    input  logic [`EX_TAG_W-1:0] tag,
    input  ex_pkg::alu_func_e    func,
    input  logic                 uncond,
    output ex_pkg::fu_op_t       op
);

    logic [`EX_XLEN-1:0] i_imm, s_imm, b_imm, u_imm, j_imm;
    logic [`EX_XLEN-1:0] opa, opb;

    // RV32 immediate formats, sign bit is always inst[31]
    assign i_imm = {{(`EX_XLEN-12){inst[31]}}, inst[31:20]};
    assign s_imm = {{(`EX_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign b_imm = {{(`EX_XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                    inst[11:8], 1'b0};
    assign u_imm = {inst[31:12], 12'b0};       // Upper 20 bits, no extension needed
    assign j_imm = {{(`EX_XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                    inst[30:21], 1'b0};

    always_comb begin
        case (opa_sel)
            ex_pkg::RS1: opa = rs1;
            ex_pkg::PC:  opa = pc;
            default:     opa = '0;             // ZERO, e.g. LUI
        endcase
        case (opb_sel)
            ex_pkg::RS2:   opb = rs2;
            ex_pkg::I_IMM: opb = i_imm;
            ex_pkg::S_IMM: opb = s_imm;
            ex_pkg::B_IMM: opb = b_imm;
            ex_pkg::U_IMM: opb = u_imm;
            ex_pkg::J_IMM: opb = j_imm;
            default:       opb = `EX_XLEN'd4;  // FOUR
        endcase
    end

    // Pack the unit-facing op
    always_comb begin
        op.tag    = tag;
        op.func   = func;
        op.opa    = opa;
        op.opb    = opb;
        op.pc     = pc;
        op.rs1    = rs1;
        op.rs2    = rs2;
        op.funct3 = inst[14:12];
        op.uncond = uncond;
    end

endmodule

//--- fu_result_if.sv
// Completion bundle from one functional unit to the control block
// Unit drives source, control reads sink; valid is a single-cycle pulse
`include "ex_settings.svh"

interface fu_result_if;

    logic                 valid;       // One pulse per finished op
    logic [`EX_TAG_W-1:0] tag;
    logic [`EX_XLEN-1:0]  value;       // Result or link value
    logic                 take_branch; // Branch unit only
    logic [`EX_XLEN-1:0]  target;      // Branch unit only

    modport source (
        output valid, tag, value, take_branch, target
    );

    modport sink (
        input valid, tag, value, take_branch, target
    );

endinterface

//--- ex_pkg.sv
// Types shared by the execute stage modules and the testbench
// Referenced with scoped names only
`include "ex_settings.svh"

package ex_pkg;

    //////////////////////////////
    // Unit selection and function codes
    //////////////////////////////

    typedef enum logic [1:0] {
        FU_ALU,
        FU_MULT,
        FU_BRANCH
    } fu_type_e;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR,
        SLT, SLTU, SLL, SRL, SRA,
        MUL, MULH, MULHSU, MULHU  // Multiplier only
    } alu_func_e;

    //////////////////////////////
    // Operand muxes
    //////////////////////////////

    typedef enum logic [1:0] {
        RS1,
        PC,
        ZERO
    } opa_sel_e;

    typedef enum logic [2:0] {
        RS2,
        I_IMM,
        S_IMM,
        B_IMM,
        U_IMM,
        J_IMM,
        FOUR    // Constant 4 for link computations
    } opb_sel_e;

    // One operation as seen by any functional unit
    typedef struct packed {
        logic [`EX_TAG_W-1:0] tag;
        alu_func_e            func;
        logic [`EX_XLEN-1:0]  opa;
        logic [`EX_XLEN-1:0]  opb;
        logic [`EX_XLEN-1:0]  pc;
        logic [`EX_XLEN-1:0]  rs1;   // Raw register values for branch compare
        logic [`EX_XLEN-1:0]  rs2;
        logic [2:0]           funct3;
        logic                 uncond; // JAL / JALR
    } fu_op_t;

endpackage

//--- ex_settings.svh
// Width and depth settings for the execute stage
// Included by the package, the result interface and every stage module
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// Data path width, one machine word
`define EX_XLEN 32

// Operation tag width, enough for 16 operations in flight
`define EX_TAG_W 4

// Multiplier latency in cycles from start to valid
// Works from 2 up to 6
`define EX_MULT_STAGES 4

`endif
